// File: include/rv_fetch_defines.svh
`ifndef RV_FETCH_DEFINES_SVH
`define RV_FETCH_DEFINES_SVH

// first fetch address out of reset
`define RESET_PC 32'h8000_0000

// fixed by the instruction set and the bus
`define PC_W 32
`define BUS_DATA_W 64
`define INST_W 32

// sequential pc step
`define INST_BYTES 4

`endif

// File: design/rv_fetch_pkg.sv
`include "rv_fetch_defines.svh"

package rv_fetch_pkg;

  // fetch pc and bus address
  typedef logic [`PC_W-1:0] pc_t;

  // one instruction word
  typedef logic [`INST_W-1:0] inst_t;

  // one read beat, two instruction words
  typedef logic [`BUS_DATA_W-1:0] bus_data_t;

  // bus master read sequence
  typedef enum logic [1:0] {
    FS_IDLE, // ready for the next request
    FS_ADDR, // AR valid, waiting for ready
    FS_DATA  // waiting for the R beat
  } fetch_state_e;

endpackage

// File: design/pc_gen.sv
`timescale 1ns/1ps
`include "rv_fetch_defines.svh"

module pc_gen import rv_fetch_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic branch_taken_i,
  input  pc_t  branch_target_i,
  input  logic ecall_i,
  input  logic mret_i,
  input  pc_t  mtvec_i,
  input  pc_t  mepc_i,
  input  logic req_ready_i,
  output logic req_valid_o,
  output pc_t  req_pc_o,
  output logic flush_o
);

  pc_t  pc_q;        // sequential pc of the next request
  logic pend_q;      // redirect seen but not yet issued
  pc_t  pend_pc_q;   // target of that redirect
  logic redirect;
  pc_t  redirect_pc;
  logic req_fire;

  // mret over ecall over branch
  always_comb begin
    redirect = mret_i | ecall_i | branch_taken_i;
    if (mret_i) begin
      redirect_pc = mepc_i;
    end else if (ecall_i) begin
      redirect_pc = mtvec_i;
    end else begin
      redirect_pc = branch_target_i;
    end
  end

  // a live redirect wins, then a held one, then the sequential pc
  always_comb begin
    if (redirect) begin
      req_pc_o = redirect_pc;
    end else if (pend_q) begin
      req_pc_o = pend_pc_q;
    end else begin
      req_pc_o = pc_q;
    end
  end

  assign req_valid_o = ~rst; // always requesting outside reset
  assign req_fire    = req_valid_o & req_ready_i;
  assign flush_o     = redirect; // squash whatever is in flight

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q   <= `RESET_PC;
      pend_q <= 1'b0;
    end else begin
      if (req_fire) begin
        pc_q   <= req_pc_o + pc_t'(`INST_BYTES);
        pend_q <= 1'b0;
      end else if (redirect) begin
        pend_q <= 1'b1; // master busy so the target is held
      end
    end
  end

  // newest target replaces an older held one
  always_ff @(posedge clk) begin
    if (redirect && !req_fire) begin
      pend_pc_q <= redirect_pc;
    end
  end

endmodule

// File: design/fetch_bus_master.sv
`timescale 1ns/1ps
`include "rv_fetch_defines.svh"

module fetch_bus_master import rv_fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid_i,
  input  pc_t       req_pc_i,
  output logic      req_ready_o,
  input  logic      flush_i,
  input  logic      stage_allowin_i,
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  output pc_t       ar_addr_o,
  input  logic      r_valid_i,
  output logic      r_ready_o,
  input  bus_data_t r_data_i,
  output logic      rsp_valid_o,
  output bus_data_t rsp_data_o,
  output pc_t       rsp_pc_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  pc_t          pc_q;      // pc of the fetch in flight
  logic         discard_q; // outstanding beat belongs to a squashed fetch
  logic         req_fire;
  logic         r_fire;

  assign req_ready_o = (state_q == FS_IDLE);
  assign req_fire    = req_valid_i & req_ready_o;

  // address held in pc_q, so it stays put until ar_ready_i
  assign ar_valid_o = (state_q == FS_ADDR);
  assign ar_addr_o  = {pc_q[`PC_W-1:3], 3'b000};

  // drain squashed beats at once, otherwise wait for room downstream
  assign r_ready_o = (state_q == FS_DATA) & (discard_q | stage_allowin_i);
  assign r_fire    = r_valid_i & r_ready_o;

  assign rsp_valid_o = r_fire & ~discard_q;
  assign rsp_data_o  = r_data_i;
  assign rsp_pc_o    = pc_q; // bit 2 picks the word downstream

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (req_valid_i) begin
          state_d = FS_ADDR;
        end
      end
      FS_ADDR: begin
        if (ar_ready_i) begin
          state_d = FS_DATA;
        end
      end
      FS_DATA: begin
        if (r_fire) begin
          state_d = FS_IDLE;
        end
      end
      default: begin
        state_d = FS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= FS_IDLE;
      discard_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (r_fire) begin
        discard_q <= 1'b0; // one outstanding read, so this is the beat
      end else if (flush_i && state_q != FS_IDLE) begin
        discard_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      pc_q <= req_pc_i;
    end
  end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_fetch_defines.svh"

module fetch_stage import rv_fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      rsp_valid_i,
  input  bus_data_t rsp_data_i,
  input  pc_t       rsp_pc_i,
  input  logic      flush_i,
  input  logic      id_allowin_i,
  output logic      stage_allowin_o,
  output logic      inst_valid_o,
  output inst_t     inst_o,
  output pc_t       inst_pc_o
);

  inst_t sel_inst;
  logic  out_valid_q;   // output register toward decode
  inst_t out_inst_q;
  pc_t   out_pc_q;
  logic  hold_valid_q;  // second slot, catches a beat while decode stalls
  inst_t hold_inst_q;
  pc_t   hold_pc_q;
  logic  out_free;

  // upper word for pc bit 2 set
  assign sel_inst = rsp_pc_i[2] ? rsp_data_i[2*`INST_W-1:`INST_W] : rsp_data_i[`INST_W-1:0];

  // wrong-path instruction is never offered in the redirect cycle
  assign inst_valid_o = out_valid_q & ~flush_i;
  assign inst_o       = out_inst_q;
  assign inst_pc_o    = out_pc_q;

  assign stage_allowin_o = ~hold_valid_q;
  assign out_free        = ~out_valid_q | (inst_valid_o & id_allowin_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q  <= 1'b0;
      hold_valid_q <= 1'b0;
    end else if (flush_i) begin
      out_valid_q  <= 1'b0;
      hold_valid_q <= 1'b0;
    end else if (out_free) begin
      // no beat can arrive while the hold slot is full
      out_valid_q  <= hold_valid_q | rsp_valid_i;
      hold_valid_q <= 1'b0;
    end else if (rsp_valid_i) begin
      hold_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (hold_valid_q) begin
        out_inst_q <= hold_inst_q; // oldest first
        out_pc_q   <= hold_pc_q;
      end else if (rsp_valid_i) begin
        out_inst_q <= sel_inst;
        out_pc_q   <= rsp_pc_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!out_free && rsp_valid_i) begin
      hold_inst_q <= sel_inst;
      hold_pc_q   <= rsp_pc_i;
    end
  end

endmodule

// File: design/rv_fetch_top.sv
`timescale 1ns/1ps

module rv_fetch_top import rv_fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // AXI read address and data
  output logic      ar_valid_o,
  input  logic      ar_ready_i,
  output pc_t       ar_addr_o,
  input  logic      r_valid_i,
  output logic      r_ready_o,
  input  bus_data_t r_data_i,

  // toward decode
  output logic      inst_valid_o,
  output inst_t     inst_o,
  output pc_t       inst_pc_o,
  input  logic      id_allowin_i,

  // redirects from decode and the csr values
  input  logic      branch_taken_i,
  input  pc_t       branch_target_i,
  input  logic      ecall_i,
  input  logic      mret_i,
  input  pc_t       mtvec_i,
  input  pc_t       mepc_i
);

  logic      req_valid;
  logic      req_ready;
  pc_t       req_pc;
  logic      flush;
  logic      rsp_valid;
  bus_data_t rsp_data;
  pc_t       rsp_pc;
  logic      stage_allowin;

  pc_gen u_pc_gen (
    .clk             (clk),
    .rst             (rst),
    .branch_taken_i  (branch_taken_i),
    .branch_target_i (branch_target_i),
    .ecall_i         (ecall_i),
    .mret_i          (mret_i),
    .mtvec_i         (mtvec_i),
    .mepc_i          (mepc_i),
    .req_ready_i     (req_ready),
    .req_valid_o     (req_valid),
    .req_pc_o        (req_pc),
    .flush_o         (flush)
  );

  fetch_bus_master u_fetch_bus_master (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid),
    .req_pc_i        (req_pc),
    .req_ready_o     (req_ready),
    .flush_i         (flush),
    .stage_allowin_i (stage_allowin),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_addr_o       (ar_addr_o),
    .r_valid_i       (r_valid_i),
    .r_ready_o       (r_ready_o),
    .r_data_i        (r_data_i),
    .rsp_valid_o     (rsp_valid),
    .rsp_data_o      (rsp_data),
    .rsp_pc_o        (rsp_pc)
  );

  fetch_stage u_fetch_stage (
    .clk             (clk),
    .rst             (rst),
    .rsp_valid_i     (rsp_valid),
    .rsp_data_i      (rsp_data),
    .rsp_pc_i        (rsp_pc),
    .flush_i         (flush),
    .id_allowin_i    (id_allowin_i),
    .stage_allowin_o (stage_allowin),
    .inst_valid_o    (inst_valid_o),
    .inst_o          (inst_o),
    .inst_pc_o       (inst_pc_o)
  );

endmodule

// File: sim/fetch_mem_model.sv
`timescale 1ns/1ps

module fetch_mem_model import rv_fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  pc_t       ar_addr_i,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output bus_data_t r_data_o
);

  integer      seed = 32'haac57bf1;
  logic [31:0] rnd;
  logic        ar_ready_q = 1'b0;
  logic        r_valid_q = 1'b0;
  bus_data_t   r_data_q = '0;
  logic        busy_q = 1'b0;    // address taken, beat not yet delivered
  logic [1:0]  ar_cnt_q = 2'd0;  // cycles left before ar_ready
  logic [1:0]  r_cnt_q = 2'd0;   // cycles left before r_valid
  pc_t         addr_q = '0;

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = r_data_q;

  // every word holds its own byte address xor a constant
  function automatic bus_data_t beat_at(input pc_t addr);
    pc_t base;
    base = {addr[31:3], 3'b000};
    return {(base + 32'd4) ^ 32'h13579bdf, base ^ 32'h13579bdf};
  endfunction

  always @(posedge clk) begin
    rnd = $random(seed);
    if (rst) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      busy_q     <= 1'b0;
      ar_cnt_q   <= 2'd0;
    end else begin
      if (ar_valid_i && ar_ready_q) begin
        ar_ready_q <= 1'b0;
        busy_q     <= 1'b1;
        addr_q     <= ar_addr_i;
        r_cnt_q    <= rnd[1:0];
        ar_cnt_q   <= rnd[3:2]; // delay for the next address
      end else if (ar_valid_i && !busy_q) begin
        if (ar_cnt_q == 2'd0) begin
          ar_ready_q <= 1'b1;
        end else begin
          ar_cnt_q <= ar_cnt_q - 2'd1;
        end
      end
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
        busy_q    <= 1'b0;
      end else if (busy_q && !r_valid_q) begin
        if (r_cnt_q == 2'd0) begin
          r_valid_q <= 1'b1;
          r_data_q  <= beat_at(addr_q);
        end else begin
          r_cnt_q <= r_cnt_q - 2'd1;
        end
      end
    end
  end

endmodule

// File: sim/fetch_tb.sv
`timescale 1ns/1ps
`include "rv_fetch_defines.svh"

module fetch_tb import rv_fetch_pkg::*; ();

  typedef struct packed {
    int         wait_n; // instructions accepted before the pulse
    logic [1:0] when;   // 0 any cycle, 1 AR waiting, 2 R outstanding
    logic       mret;
    logic       ecall;
    logic       branch;
    pc_t        target;
    pc_t        mtvec;
    pc_t        mepc;
    pc_t        exp_pc;
  } redir_row_t;

  localparam int NUM_ROWS       = 11;
  localparam int ACCEPT_TIMEOUT = 2000;
  localparam int STATE_TIMEOUT  = 200;

  redir_row_t rows [NUM_ROWS] = '{
    '{10, 2'd0, 1'b0, 1'b0, 1'b1, 32'h8000_0100, 32'h0, 32'h0, 32'h8000_0100},
    '{6, 2'd0, 1'b0, 1'b0, 1'b1, 32'h8000_0204, 32'h0, 32'h0, 32'h8000_0204},
    '{5, 2'd0, 1'b1, 1'b1, 1'b1, 32'h8000_1000, 32'h8000_2000, 32'h8000_3004, 32'h8000_3004},
    '{5, 2'd0, 1'b0, 1'b1, 1'b1, 32'h8000_1100, 32'h8000_2100, 32'h8000_3100, 32'h8000_2100},
    '{5, 2'd0, 1'b0, 1'b1, 1'b0, 32'h8000_1200, 32'h8000_2204, 32'h8000_3200, 32'h8000_2204},
    '{4, 2'd1, 1'b0, 1'b0, 1'b1, 32'h8000_4000, 32'h0, 32'h0, 32'h8000_4000},
    '{4, 2'd2, 1'b0, 1'b0, 1'b1, 32'h8000_4104, 32'h0, 32'h0, 32'h8000_4104},
    '{3, 2'd2, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0, 32'h8000_5008, 32'h8000_5008},
    '{3, 2'd1, 1'b0, 1'b1, 1'b0, 32'h0, 32'h8000_600c, 32'h0, 32'h8000_600c},
    '{0, 2'd0, 1'b0, 1'b0, 1'b1, 32'h8000_7000, 32'h0, 32'h0, 32'h8000_7000}, // replaces held one
    '{6, 2'd2, 1'b0, 1'b0, 1'b1, 32'h8000_0ff8, 32'h0, 32'h0, 32'h8000_0ff8}
  };

  logic      clk;
  logic      rst;
  logic      ar_valid_o;
  logic      ar_ready_i;
  pc_t       ar_addr_o;
  logic      r_valid_i;
  logic      r_ready_o;
  bus_data_t r_data_i;
  logic      inst_valid_o;
  inst_t     inst_o;
  pc_t       inst_pc_o;
  logic      id_allowin_i = 1'b0;
  logic      branch_taken_i;
  logic      ecall_i;
  logic      mret_i;
  pc_t       branch_target_i;
  pc_t       mtvec_i;
  pc_t       mepc_i;

  integer      seed = 32'haac57bf1;
  logic [31:0] stall_rnd;
  pc_t         redir_exp = '0;  // where the pending pulse should land
  pc_t         exp_pc = `RESET_PC;
  int          accept_cnt = 0;
  int          err_cnt = 0;
  int          timeout_cnt = 0;
  int          cyc = 0;
  logic        timed_out = 1'b0;
  logic        rd_pend;
  logic        redir_now;
  logic        post_redir = 1'b0;
  logic        seen_ar = 1'b0;
  logic        ar_hold = 1'b0;
  pc_t         ar_addr_prev;
  logic        prev_stall = 1'b0;
  pc_t         prev_pc;

  rv_fetch_top rv_fetch_top_inst (
    .clk             (clk),
    .rst             (rst),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_addr_o       (ar_addr_o),
    .r_valid_i       (r_valid_i),
    .r_ready_o       (r_ready_o),
    .r_data_i        (r_data_i),
    .inst_valid_o    (inst_valid_o),
    .inst_o          (inst_o),
    .inst_pc_o       (inst_pc_o),
    .id_allowin_i    (id_allowin_i),
    .branch_taken_i  (branch_taken_i),
    .branch_target_i (branch_target_i),
    .ecall_i         (ecall_i),
    .mret_i          (mret_i),
    .mtvec_i         (mtvec_i),
    .mepc_i          (mepc_i)
  );

  fetch_mem_model mem_model_inst (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid_o),
    .ar_ready_o (ar_ready_i),
    .ar_addr_i  (ar_addr_o),
    .r_valid_o  (r_valid_i),
    .r_ready_i  (r_ready_o),
    .r_data_o   (r_data_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // decode stalls about a quarter of the cycles
  always @(posedge clk) begin
    stall_rnd = $random(seed);
    id_allowin_i <= (stall_rnd[1:0] != 2'd0);
  end

  // read in flight between the AR and R handshakes
  always @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
    end else if (ar_valid_o && ar_ready_i) begin
      rd_pend <= 1'b1;
    end else if (r_valid_i && r_ready_o) begin
      rd_pend <= 1'b0;
    end
  end

  // memory rule, a word is its address xor a constant
  function automatic inst_t word_at(input pc_t pc);
    return pc ^ 32'h13579bdf;
  endfunction

  always @(posedge clk) begin
    redir_now = branch_taken_i | ecall_i | mret_i;
    if (rst) begin
      if (cyc > 0) begin
        assert (!inst_valid_o && !ar_valid_o && !r_ready_o) else begin
          err_cnt++;
          $display("ERR reset: inst_valid_o %h ar_valid_o %h r_ready_o %h expected 0",
                   inst_valid_o, ar_valid_o, r_ready_o);
        end
      end
    end else begin
      if (ar_valid_o && !seen_ar) begin
        seen_ar = 1'b1;
        assert (ar_addr_o == (`RESET_PC & 32'hffff_fff8)) else begin
          err_cnt++;
          $display("ERR ar_addr_o got %h expected %h", ar_addr_o, `RESET_PC & 32'hffff_fff8);
        end
      end
      if (ar_hold) begin // AR must not move before ar_ready
        assert (ar_valid_o && ar_addr_o == ar_addr_prev) else begin
          err_cnt++;
          $display("ERR ar_addr_o got %h (valid %h) expected %h", ar_addr_o, ar_valid_o,
                   ar_addr_prev);
        end
      end
      if (prev_stall && !redir_now) begin
        assert (inst_valid_o && inst_pc_o == prev_pc) else begin
          err_cnt++;
          $display("ERR inst_pc_o got %h expected %h held", inst_pc_o, prev_pc);
        end
      end
      if (redir_now || post_redir) begin
        assert (!inst_valid_o) else begin
          err_cnt++;
          $display("ERR inst_valid_o got %h expected 0 around a redirect", inst_valid_o);
        end
      end
      if (inst_valid_o && id_allowin_i) begin
        assert (inst_pc_o == exp_pc) else begin
          err_cnt++;
          $display("ERR inst_pc_o got %h expected %h", inst_pc_o, exp_pc);
        end
        assert (inst_o == word_at(exp_pc)) else begin
          err_cnt++;
          $display("ERR inst_o got %h expected %h", inst_o, word_at(exp_pc));
        end
        exp_pc = exp_pc + pc_t'(`INST_BYTES);
        accept_cnt++;
      end
      if (redir_now) begin
        exp_pc = redir_exp;
      end
    end
    ar_hold    = !rst && ar_valid_o && !ar_ready_i;
    ar_addr_prev = ar_addr_o;
    prev_stall = !rst && inst_valid_o && !id_allowin_i;
    prev_pc    = inst_pc_o;
    post_redir = !rst && redir_now;
    cyc++;
  end

  task automatic wait_accepts(input int goal);
    int n;
    n = 0;
    while (accept_cnt < goal && n < ACCEPT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (accept_cnt < goal) begin
      timeout_cnt++;
      timed_out = 1'b1;
      $display("timeout: decode received %0d instructions, waited for %0d", accept_cnt, goal);
    end
  endtask

  task automatic wait_bus_state(input logic [1:0] when);
    int   n;
    logic hit;
    n = 0;
    hit = (when == 2'd0);
    while (!hit && n < STATE_TIMEOUT) begin
      if (when == 2'd1) begin
        hit = ar_valid_o && !ar_ready_i;
      end else begin
        hit = rd_pend && !(r_valid_i && r_ready_o);
      end
      if (!hit) begin
        @(negedge clk);
        n++;
      end
    end
    if (!hit) begin
      timeout_cnt++;
      timed_out = 1'b1;
      $display("timeout: no outstanding fetch seen to redirect against");
    end
  endtask

  // one-cycle pulse, launched on a rising edge
  task automatic pulse_redirect(input redir_row_t row);
    @(posedge clk);
    branch_taken_i  <= row.branch;
    ecall_i         <= row.ecall;
    mret_i          <= row.mret;
    branch_target_i <= row.target;
    mtvec_i         <= row.mtvec;
    mepc_i          <= row.mepc;
    redir_exp       <= row.exp_pc;
    @(posedge clk);
    branch_taken_i <= 1'b0;
    ecall_i        <= 1'b0;
    mret_i         <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    int i;
    rst             = 1'b1;
    branch_taken_i  = 1'b0;
    ecall_i         = 1'b0;
    mret_i          = 1'b0;
    branch_target_i = '0;
    mtvec_i         = '0;
    mepc_i          = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    for (i = 0; i < NUM_ROWS && !timed_out; i++) begin
      wait_accepts(accept_cnt + rows[i].wait_n);
      if (!timed_out) begin
        wait_bus_state(rows[i].when);
      end
      if (!timed_out) begin
        pulse_redirect(rows[i]);
      end
    end
    if (!timed_out) begin
      wait_accepts(accept_cnt + 12); // run on past the last target
    end
    $display("fetch_tb: %0d instructions, %0d value errors, %0d timeouts",
             accept_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: rv_fetch.f
+incdir+include
design/rv_fetch_pkg.sv
design/pc_gen.sv
design/fetch_bus_master.sv
design/fetch_stage.sv
design/rv_fetch_top.sv
sim/fetch_mem_model.sv
sim/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=fetch_tb.log
BIN=fetch_tb_sim

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -f rv_fetch.f \
  --top-module fetch_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "run.sh: verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  echo "run.sh: PASS"
  exit 0
fi
echo "run.sh: FAIL"
exit 1
